/* include/lsu_defs_defs.svh */
// word and register widths, load/store type codes, axi responses, sram depth and delays
`ifndef LSU_DEFS_DEFS_SVH
`define LSU_DEFS_DEFS_SVH

// datapath widths
`define LSU_XLEN 32
`define LSU_REG_IDX_W 5

// load type codes, 3 bits
`define LSU_LOAD_NONE 3'd0
`define LSU_LOAD_LB 3'd1
`define LSU_LOAD_LH 3'd2
`define LSU_LOAD_LW 3'd3
`define LSU_LOAD_LBU 3'd4
`define LSU_LOAD_LHU 3'd5

// store type codes, 2 bits
`define LSU_STORE_NONE 2'd0
`define LSU_STORE_SB 2'd1
`define LSU_STORE_SH 2'd2
`define LSU_STORE_SW 2'd3

// axi responses
`define LSU_RESP_OKAY 2'b00
`define LSU_RESP_SLVERR 2'b10

// sram depth in words and channel delays in cycles
`define LSU_SRAM_WORDS 256
`define LSU_SRAM_AR_DELAY 1
`define LSU_SRAM_AW_DELAY 2
`define LSU_SRAM_R_DELAY 2
`define LSU_SRAM_B_DELAY 1

`endif

/* verilog/lsu_pkg.sv */
// shared vector types, request/write-back/axi structs and controller state enum
`include "lsu_defs_defs.svh"

package lsu_pkg;

	typedef logic [`LSU_XLEN-1:0] data_t;
	typedef logic [`LSU_XLEN-1:0] addr_t;
	typedef logic [`LSU_XLEN/8-1:0] strb_t;
	typedef logic [`LSU_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [2:0] load_type_t;
	typedef logic [1:0] store_type_t;
	typedef logic [1:0] resp_t;

	// request from execute, addr is the alu result
	typedef struct packed {
		addr_t       addr;
		data_t       wdata;
		load_type_t  load_type;
		store_type_t store_type;
		reg_idx_t    rd;
		logic        wb_en;
	} lsu_req_t;

	typedef struct packed {
		reg_idx_t rd;
		logic     wb_en;
		data_t    data;
		logic     err;
	} lsu_wb_t;

	// shared by ar and aw
	typedef struct packed {
		addr_t addr;
	} axi_addr_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} axi_w_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} axi_r_t;

	typedef enum logic [1:0] {
		LSU_IDLE,
		LSU_ADDR,
		LSU_RESP,
		LSU_DONE
	} lsu_state_e;

endpackage

/* verilog/lsu_store_align.sv */
// store lane alignment: byte strobe and shifted write data from store type and offset
`timescale 1ns/1ps
`include "lsu_defs_defs.svh"

module lsu_store_align (
	input  lsu_pkg::store_type_t store_type_i,
	input  logic [1:0]           addr_lo_i,
	input  lsu_pkg::data_t       wdata_i,
	output lsu_pkg::axi_w_t      w_o
);

	lsu_pkg::strb_t base_strb;
	logic [4:0]     bit_shift;

	// strobe for the access size before the lane offset
	always_comb begin
		case (store_type_i)
			`LSU_STORE_SB: begin
				base_strb = 4'b0001;
			end
			`LSU_STORE_SH: begin
				base_strb = 4'b0011;
			end
			`LSU_STORE_SW: begin
				base_strb = 4'b1111;
			end
			default: begin
				base_strb = 4'b0000;
			end
		endcase
	end

	// byte offset times eight
	assign bit_shift = {addr_lo_i, 3'b000};

	// low bytes of the store data land on the strobed lanes
	assign w_o.strb = base_strb << addr_lo_i;
	assign w_o.data = wdata_i << bit_shift;

endmodule

/* verilog/lsu_load_extend.sv */
// load lane select with sign or zero extension for byte and halfword loads
`timescale 1ns/1ps
`include "lsu_defs_defs.svh"

module lsu_load_extend (
	input  lsu_pkg::load_type_t load_type_i,
	input  logic [1:0]          addr_lo_i,
	input  lsu_pkg::data_t      rdata_i,
	output lsu_pkg::data_t      data_o
);

	lsu_pkg::data_t shifted;
	logic [4:0]     bit_shift;

	assign bit_shift = {addr_lo_i, 3'b000};

	// addressed lane moved down to bit 0
	assign shifted = rdata_i >> bit_shift;

	always_comb begin
		case (load_type_i)
			`LSU_LOAD_LB: begin
				data_o = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
			end
			`LSU_LOAD_LH: begin
				data_o = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
			end
			`LSU_LOAD_LBU: begin
				data_o = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
			end
			`LSU_LOAD_LHU: begin
				data_o = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
			end
			default: begin
				// lw, offset is zero for aligned words
				data_o = shifted;
			end
		endcase
	end

endmodule

/* verilog/lsu_ctrl.sv */
// memory-stage FSM: request capture, axi-lite master channels and write-back result
`timescale 1ns/1ps
`include "lsu_defs_defs.svh"

module lsu_ctrl (
	input  logic                clock,
	input  logic                rstn,
	input  logic                req_valid_i,
	input  lsu_pkg::lsu_req_t   req_i,
	output logic                ar_valid_o,
	output lsu_pkg::axi_addr_t  ar_addr_o,
	input  logic                ar_ready_i,
	input  lsu_pkg::axi_r_t     r_i,
	input  logic                r_valid_i,
	output logic                r_ready_o,
	output logic                aw_valid_o,
	output lsu_pkg::axi_addr_t  aw_addr_o,
	input  logic                aw_ready_i,
	output lsu_pkg::axi_w_t     w_o,
	output logic                w_valid_o,
	input  logic                w_ready_i,
	input  lsu_pkg::resp_t      b_resp_i,
	input  logic                b_valid_i,
	output logic                b_ready_o,
	output logic                done_o,
	output lsu_pkg::lsu_wb_t    wb_o
);

	lsu_pkg::lsu_state_e state_q;
	lsu_pkg::lsu_state_e state_d;
	lsu_pkg::lsu_req_t   req_q;
	lsu_pkg::data_t      wb_data_q;
	logic                wb_err_q;
	logic                aw_done_q;
	logic                w_done_q;
	logic                is_load;
	logic                is_store;
	logic                ar_fire;
	logic                r_fire;
	logic                aw_fire;
	logic                w_fire;
	logic                b_fire;
	logic                aw_ok;
	logic                w_ok;
	lsu_pkg::data_t      load_data;
	lsu_pkg::addr_t      word_addr;

	// a load wins if both types are set
	assign is_load  = req_q.load_type != `LSU_LOAD_NONE;
	assign is_store = !is_load && (req_q.store_type != `LSU_STORE_NONE);

	assign word_addr = {req_q.addr[`LSU_XLEN-1:2], 2'b00};
	assign ar_addr_o.addr = word_addr;
	assign aw_addr_o.addr = word_addr;

	assign ar_valid_o = (state_q == lsu_pkg::LSU_ADDR) && is_load;
	assign aw_valid_o = (state_q == lsu_pkg::LSU_ADDR) && is_store && !aw_done_q;
	assign w_valid_o  = (state_q == lsu_pkg::LSU_ADDR) && is_store && !w_done_q;
	assign r_ready_o  = (state_q == lsu_pkg::LSU_RESP) && is_load;
	assign b_ready_o  = (state_q == lsu_pkg::LSU_RESP) && is_store;
	assign done_o     = state_q == lsu_pkg::LSU_DONE;

	assign ar_fire = ar_valid_o && ar_ready_i;
	assign r_fire  = r_valid_i && r_ready_o;
	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire  = w_valid_o && w_ready_i;
	assign b_fire  = b_valid_i && b_ready_o;

	// aw and w may finish on different edges
	assign aw_ok = aw_done_q || aw_fire;
	assign w_ok  = w_done_q || w_fire;

	lsu_store_align u_store_align (
		.store_type_i (req_q.store_type),
		.addr_lo_i    (req_q.addr[1:0]),
		.wdata_i      (req_q.wdata),
		.w_o          (w_o)
	);

	lsu_load_extend u_load_extend (
		.load_type_i (req_q.load_type),
		.addr_lo_i   (req_q.addr[1:0]),
		.rdata_i     (r_i.data),
		.data_o      (load_data)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			lsu_pkg::LSU_IDLE: begin
				if (req_valid_i) begin
					state_d = lsu_pkg::LSU_ADDR;
				end
			end
			lsu_pkg::LSU_ADDR: begin
				if (!is_load && !is_store) begin
					state_d = lsu_pkg::LSU_DONE;
				end else if (is_load && ar_fire) begin
					state_d = lsu_pkg::LSU_RESP;
				end else if (is_store && aw_ok && w_ok) begin
					state_d = lsu_pkg::LSU_RESP;
				end
			end
			lsu_pkg::LSU_RESP: begin
				if (r_fire || b_fire) begin
					state_d = lsu_pkg::LSU_DONE;
				end
			end
			default: begin
				state_d = lsu_pkg::LSU_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= lsu_pkg::LSU_IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == lsu_pkg::LSU_IDLE) begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
			end else begin
				aw_done_q <= aw_done_q || aw_fire;
				w_done_q  <= w_done_q || w_fire;
			end
		end
	end

	// request and write-back payload
	always_ff @(posedge clock) begin
		if ((state_q == lsu_pkg::LSU_IDLE) && req_valid_i) begin
			req_q <= req_i;
		end
		if ((state_q == lsu_pkg::LSU_ADDR) && !is_load && !is_store) begin
			wb_data_q <= req_q.addr;
			wb_err_q  <= 1'b0;
		end
		if (r_fire) begin
			wb_data_q <= load_data;
			wb_err_q  <= |r_i.resp;
		end
		if (b_fire) begin
			wb_data_q <= req_q.addr;
			wb_err_q  <= |b_resp_i;
		end
	end

	assign wb_o.rd    = req_q.rd;
	assign wb_o.wb_en = req_q.wb_en;
	assign wb_o.data  = wb_data_q;
	assign wb_o.err   = wb_err_q;

endmodule

/* verilog/axi_lite_sram.sv */
// axi-lite sram slave with byte-strobed writes, fixed channel delays and range check
`timescale 1ns/1ps
`include "lsu_defs_defs.svh"

module axi_lite_sram #(
	parameter int WORDS = `LSU_SRAM_WORDS
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                ar_valid_i,
	input  lsu_pkg::axi_addr_t  ar_addr_i,
	output logic                ar_ready_o,
	output lsu_pkg::axi_r_t     r_o,
	output logic                r_valid_o,
	input  logic                r_ready_i,
	input  logic                aw_valid_i,
	input  lsu_pkg::axi_addr_t  aw_addr_i,
	output logic                aw_ready_o,
	input  lsu_pkg::axi_w_t     w_i,
	input  logic                w_valid_i,
	output logic                w_ready_o,
	output lsu_pkg::resp_t      b_resp_o,
	output logic                b_valid_o,
	input  logic                b_ready_i
);

	localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
	localparam int CNT_W = 4;
	localparam int AR_DELAY = `LSU_SRAM_AR_DELAY;
	localparam int AW_DELAY = `LSU_SRAM_AW_DELAY;
	localparam int R_DELAY = `LSU_SRAM_R_DELAY;
	localparam int B_DELAY = `LSU_SRAM_B_DELAY;

	lsu_pkg::data_t   mem [WORDS];
	logic [CNT_W-1:0] ar_cnt_q;
	logic [CNT_W-1:0] aw_cnt_q;
	logic [CNT_W-1:0] r_cnt_q;
	logic [CNT_W-1:0] b_cnt_q;
	logic             rd_pend_q;
	logic             r_valid_q;
	logic             aw_got_q;
	logic             w_got_q;
	logic             b_valid_q;
	lsu_pkg::addr_t   rd_addr_q;
	lsu_pkg::addr_t   wr_addr_q;
	lsu_pkg::axi_w_t  wr_q;
	lsu_pkg::axi_r_t  r_q;
	lsu_pkg::resp_t   b_resp_q;
	logic             wr_pend;
	logic             r_set;
	logic             b_set;
	logic             rd_ok;
	logic             wr_ok;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	// ready once valid has waited its delay, one transaction at a time
	assign ar_ready_o = ar_valid_i && !rd_pend_q && (ar_cnt_q >= AR_DELAY);
	assign aw_ready_o = aw_valid_i && !aw_got_q && (aw_cnt_q >= AW_DELAY);
	// write data taken at once, so W usually lands before AW
	assign w_ready_o = w_valid_i && !w_got_q;

	assign wr_pend = aw_got_q && w_got_q;
	assign r_set = rd_pend_q && !r_valid_q && ((32'(r_cnt_q) + 32'd1) >= R_DELAY);
	assign b_set = wr_pend && !b_valid_q && ((32'(b_cnt_q) + 32'd1) >= B_DELAY);

	// anything at or past WORDS*4 is slverr
	assign rd_ok  = (rd_addr_q >> 2) < WORDS;
	assign wr_ok  = (wr_addr_q >> 2) < WORDS;
	assign rd_idx = rd_addr_q[IDX_W+1:2];
	assign wr_idx = wr_addr_q[IDX_W+1:2];

	// read channel control
	always_ff @(posedge clock) begin
		if (!rstn) begin
			ar_cnt_q  <= '0;
			r_cnt_q   <= '0;
			rd_pend_q <= 1'b0;
			r_valid_q <= 1'b0;
		end else begin
			if (ar_valid_i && ar_ready_o) begin
				ar_cnt_q  <= '0;
				r_cnt_q   <= '0;
				rd_pend_q <= 1'b1;
			end else if (ar_valid_i && !rd_pend_q) begin
				ar_cnt_q <= ar_cnt_q + 1'b1;
			end
			if (r_set) begin
				r_valid_q <= 1'b1;
			end else if (rd_pend_q && !r_valid_q) begin
				r_cnt_q <= r_cnt_q + 1'b1;
			end
			if (r_valid_q && r_ready_i) begin
				r_valid_q <= 1'b0;
				rd_pend_q <= 1'b0;
			end
		end
	end

	// write channel control
	always_ff @(posedge clock) begin
		if (!rstn) begin
			aw_cnt_q  <= '0;
			b_cnt_q   <= '0;
			aw_got_q  <= 1'b0;
			w_got_q   <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (aw_valid_i && aw_ready_o) begin
				aw_cnt_q <= '0;
				aw_got_q <= 1'b1;
			end else if (aw_valid_i && !aw_got_q) begin
				aw_cnt_q <= aw_cnt_q + 1'b1;
			end
			if (w_valid_i && w_ready_o) begin
				w_got_q <= 1'b1;
			end
			if (b_set) begin
				b_valid_q <= 1'b1;
			end else if (wr_pend && !b_valid_q) begin
				b_cnt_q <= b_cnt_q + 1'b1;
			end
			if (b_valid_q && b_ready_i) begin
				aw_got_q  <= 1'b0;
				w_got_q   <= 1'b0;
				b_valid_q <= 1'b0;
				b_cnt_q   <= '0;
			end
		end
	end

	// storage, captured addresses and response payload
	always_ff @(posedge clock) begin
		if (ar_valid_i && ar_ready_o) begin
			rd_addr_q <= ar_addr_i.addr;
		end
		if (aw_valid_i && aw_ready_o) begin
			wr_addr_q <= aw_addr_i.addr;
		end
		if (w_valid_i && w_ready_o) begin
			wr_q <= w_i;
		end
		if (r_set) begin
			r_q.data <= rd_ok ? mem[rd_idx] : '0;
			r_q.resp <= rd_ok ? `LSU_RESP_OKAY : `LSU_RESP_SLVERR;
		end
		if (b_set) begin
			b_resp_q <= wr_ok ? `LSU_RESP_OKAY : `LSU_RESP_SLVERR;
			if (wr_ok) begin
				for (int i = 0; i < `LSU_XLEN/8; i++) begin
					if (wr_q.strb[i]) begin
						mem[wr_idx][8*i +: 8] <= wr_q.data[8*i +: 8];
					end
				end
			end
		end
	end

	assign r_o       = r_q;
	assign r_valid_o = r_valid_q;
	assign b_resp_o  = b_resp_q;
	assign b_valid_o = b_valid_q;

endmodule

/* verilog/lsu_mem_top.sv */
// memory stage top: controller and axi-lite sram joined by the five channels
`timescale 1ns/1ps

module lsu_mem_top (
	input  logic               clock,
	input  logic               rstn,
	input  logic               req_valid_i,
	input  lsu_pkg::lsu_req_t  req_i,
	output logic               done_o,
	output lsu_pkg::lsu_wb_t   wb_o
);

	logic               ar_valid;
	lsu_pkg::axi_addr_t ar_addr;
	logic               ar_ready;
	lsu_pkg::axi_r_t    r;
	logic               r_valid;
	logic               r_ready;
	logic               aw_valid;
	lsu_pkg::axi_addr_t aw_addr;
	logic               aw_ready;
	lsu_pkg::axi_w_t    w;
	logic               w_valid;
	logic               w_ready;
	lsu_pkg::resp_t     b_resp;
	logic               b_valid;
	logic               b_ready;

	lsu_ctrl u_ctrl (
		.clock       (clock),
		.rstn        (rstn),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.ar_valid_o  (ar_valid),
		.ar_addr_o   (ar_addr),
		.ar_ready_i  (ar_ready),
		.r_i         (r),
		.r_valid_i   (r_valid),
		.r_ready_o   (r_ready),
		.aw_valid_o  (aw_valid),
		.aw_addr_o   (aw_addr),
		.aw_ready_i  (aw_ready),
		.w_o         (w),
		.w_valid_o   (w_valid),
		.w_ready_i   (w_ready),
		.b_resp_i    (b_resp),
		.b_valid_i   (b_valid),
		.b_ready_o   (b_ready),
		.done_o      (done_o),
		.wb_o        (wb_o)
	);

	axi_lite_sram u_sram (
		.clock      (clock),
		.rstn       (rstn),
		.ar_valid_i (ar_valid),
		.ar_addr_i  (ar_addr),
		.ar_ready_o (ar_ready),
		.r_o        (r),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.aw_valid_i (aw_valid),
		.aw_addr_i  (aw_addr),
		.aw_ready_o (aw_ready),
		.w_i        (w),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.b_resp_o   (b_resp),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

endmodule

/* verif/lsu_mem_tb.sv */
// testbench for lsu_mem_top with clock, reset, timeout, directed tests and byte reference memory
`timescale 1ns/1ps
`include "lsu_defs_defs.svh"

module lsu_mem_tb;

	localparam int MEM_BYTES = `LSU_SRAM_WORDS * 4;
	// about 80 requests at under 20 cycles each plus generous margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic              clock;
	logic              rstn;
	logic              req_valid_i;
	lsu_pkg::lsu_req_t req_i;
	logic              done_o;
	lsu_pkg::lsu_wb_t  wb_o;

	logic [7:0]  ref_mem [MEM_BYTES];
	int          cycle_count;

	lsu_mem_top u_dut (
		.clock       (clock),
		.rstn        (rstn),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.done_o      (done_o),
		.wb_o        (wb_o)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$fatal(1, "simulation timed out");
	end

	task automatic check(input bit ok, input string msg);
		assert (ok) else begin
			$display("ERROR: %0t ns: %s", $time, msg);
			$display("STATUS: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	function automatic lsu_pkg::lsu_req_t make_req(input lsu_pkg::addr_t addr,
			input lsu_pkg::data_t wdata, input lsu_pkg::load_type_t ltype,
			input lsu_pkg::store_type_t stype, input lsu_pkg::reg_idx_t rd, input logic wb_en);
		lsu_pkg::lsu_req_t req;
		req.addr       = addr;
		req.wdata      = wdata;
		req.load_type  = ltype;
		req.store_type = stype;
		req.rd         = rd;
		req.wb_en      = wb_en;
		return req;
	endfunction

	// little-endian lanes with the low bytes of the store data first
	function automatic void ref_store(input int unsigned addr, input lsu_pkg::store_type_t stype,
			input lsu_pkg::data_t wdata);
		int nbytes;
		case (stype)
			`LSU_STORE_SB: nbytes = 1;
			`LSU_STORE_SH: nbytes = 2;
			`LSU_STORE_SW: nbytes = 4;
			default: nbytes = 0;
		endcase
		for (int i = 0; i < nbytes; i++) begin
			ref_mem[addr + i] = wdata[8*i +: 8];
		end
	endfunction

	function automatic lsu_pkg::data_t ref_word(input int unsigned addr);
		return {ref_mem[addr + 3], ref_mem[addr + 2], ref_mem[addr + 1], ref_mem[addr]};
	endfunction

	function automatic lsu_pkg::data_t ref_load(input int unsigned addr,
			input lsu_pkg::load_type_t ltype);
		case (ltype)
			`LSU_LOAD_LB: return {{24{ref_mem[addr][7]}}, ref_mem[addr]};
			`LSU_LOAD_LBU: return {24'd0, ref_mem[addr]};
			`LSU_LOAD_LH: return {{16{ref_mem[addr + 1][7]}}, ref_mem[addr + 1], ref_mem[addr]};
			`LSU_LOAD_LHU: return {16'd0, ref_mem[addr + 1], ref_mem[addr]};
			default: return ref_word(addr);
		endcase
	endfunction

	// one request and the falling edges counted from the accepting edge to done_o
	task automatic run_req(input lsu_pkg::lsu_req_t req, input bit extra_pulse,
			output lsu_pkg::lsu_wb_t wb, output int cycles);
		bit seen;
		@(posedge clock);
		#5;
		req_i       = req;
		req_valid_i = 1'b1;
		@(posedge clock);
		#5;
		req_valid_i = 1'b0;
		cycles = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(negedge clock);
			cycles++;
			if (done_o) begin
				seen = 1'b1;
				wb   = wb_o;
			end else if (extra_pulse && (cycles == 1 || cycles == 2)) begin
				// second valid pulse while the FSM is busy
				@(posedge clock);
				#5;
				req_valid_i = (cycles == 1);
			end
		end
		@(negedge clock);
		check(!done_o, "done_o stayed high for more than one cycle");
	endtask

	task automatic no_extra_done();
		repeat (8) begin
			@(negedge clock);
			check(!done_o, "done_o pulsed without an accepted request");
		end
	endtask

	task automatic store_op(input int unsigned addr, input lsu_pkg::store_type_t stype,
			input lsu_pkg::data_t wdata, input bit expect_err, input bit extra_pulse);
		lsu_pkg::lsu_req_t req;
		lsu_pkg::lsu_wb_t  wb;
		int                cycles;
		req = make_req(addr, wdata, `LSU_LOAD_NONE, stype, lsu_pkg::reg_idx_t'($urandom), 1'b0);
		run_req(req, extra_pulse, wb, cycles);
		check(wb.err == expect_err,
			$sformatf("store at %h: err %b, expected %b", addr, wb.err, expect_err));
		check(wb.rd == req.rd && wb.wb_en == req.wb_en,
			$sformatf("store at %h: rd/wb_en %0d/%b, expected %0d/%b",
				addr, wb.rd, wb.wb_en, req.rd, req.wb_en));
		if (!expect_err) begin
			ref_store(addr, stype, wdata);
		end
	endtask

	task automatic load_op(input int unsigned addr, input lsu_pkg::load_type_t ltype,
			input bit expect_err, input bit extra_pulse, output lsu_pkg::data_t data);
		lsu_pkg::lsu_req_t req;
		lsu_pkg::lsu_wb_t  wb;
		int                cycles;
		req = make_req(addr, $urandom, ltype, `LSU_STORE_NONE, lsu_pkg::reg_idx_t'($urandom), 1'b1);
		run_req(req, extra_pulse, wb, cycles);
		check(wb.err == expect_err,
			$sformatf("load at %h: err %b, expected %b", addr, wb.err, expect_err));
		check(wb.rd == req.rd && wb.wb_en == req.wb_en,
			$sformatf("load at %h: rd %0d, expected %0d", addr, wb.rd, req.rd));
		data = wb.data;
	endtask

	task automatic load_check(input int unsigned addr, input lsu_pkg::load_type_t ltype);
		lsu_pkg::data_t data;
		lsu_pkg::data_t expected;
		load_op(addr, ltype, 1'b0, 1'b0, data);
		expected = ref_load(addr, ltype);
		check(data == expected,
			$sformatf("load type %0d at %h: got %h, expected %h", ltype, addr, data, expected));
	endtask

	task automatic test_pass_through();
		lsu_pkg::lsu_req_t req;
		lsu_pkg::lsu_wb_t  wb;
		int                cycles;
		for (int i = 0; i < 4; i++) begin
			req = make_req($urandom, $urandom, `LSU_LOAD_NONE, `LSU_STORE_NONE,
				lsu_pkg::reg_idx_t'($urandom), 1'($urandom));
			run_req(req, 1'b0, wb, cycles);
			check(wb.data == req.addr,
				$sformatf("pass-through data %h, expected %h", wb.data, req.addr));
			check(wb.rd == req.rd && wb.wb_en == req.wb_en && !wb.err,
				$sformatf("pass-through rd/wb_en/err %0d/%b/%b", wb.rd, wb.wb_en, wb.err));
			check(cycles == 2, $sformatf("pass-through done after %0d cycles, expected 2", cycles));
		end
	endtask

	task automatic test_word_rw();
		int unsigned    addr;
		lsu_pkg::data_t wdata;
		lsu_pkg::data_t data;
		for (int i = 0; i < 8; i++) begin
			addr  = ($urandom % `LSU_SRAM_WORDS) * 4;
			wdata = $urandom;
			store_op(addr, `LSU_STORE_SW, wdata, 1'b0, 1'b0);
			load_op(addr, `LSU_LOAD_LW, 1'b0, 1'b0, data);
			check(data == wdata, $sformatf("word at %h: got %h, expected %h", addr, data, wdata));
		end
	endtask

	task automatic test_partial_stores();
		int unsigned addr;
		for (int i = 0; i < 2; i++) begin
			addr = ($urandom % `LSU_SRAM_WORDS) * 4;
			store_op(addr, `LSU_STORE_SW, $urandom, 1'b0, 1'b0);
			// random upper bytes must not leak into other lanes
			for (int off = 0; off < 4; off++) begin
				store_op(addr + off, `LSU_STORE_SB, $urandom, 1'b0, 1'b0);
				load_check(addr, `LSU_LOAD_LW);
			end
			for (int off = 0; off < 4; off += 2) begin
				store_op(addr + off, `LSU_STORE_SH, $urandom, 1'b0, 1'b0);
				load_check(addr, `LSU_LOAD_LW);
			end
		end
	endtask

	task automatic test_load_extend();
		int unsigned    addr;
		lsu_pkg::data_t value;
		for (int i = 0; i < 2; i++) begin
			addr  = ($urandom % `LSU_SRAM_WORDS) * 4;
			value = $urandom;
			// every byte sign bit set and then every one clear
			value = (i == 0) ? (value | 32'h8080_8080) : (value & 32'h7f7f_7f7f);
			store_op(addr, `LSU_STORE_SW, value, 1'b0, 1'b0);
			for (int off = 0; off < 4; off++) begin
				load_check(addr + off, `LSU_LOAD_LB);
				load_check(addr + off, `LSU_LOAD_LBU);
			end
			for (int off = 0; off < 4; off += 2) begin
				load_check(addr + off, `LSU_LOAD_LH);
				load_check(addr + off, `LSU_LOAD_LHU);
			end
		end
	endtask

	task automatic test_out_of_range();
		int unsigned    addr;
		int unsigned    bad_addr;
		lsu_pkg::data_t data;
		addr     = ($urandom % `LSU_SRAM_WORDS) * 4;
		// same low index bits as addr so a wrong write would show up there
		bad_addr = addr + MEM_BYTES;
		store_op(addr, `LSU_STORE_SW, $urandom, 1'b0, 1'b0);
		load_op(bad_addr, `LSU_LOAD_LW, 1'b1, 1'b1, data);
		check(data == '0, $sformatf("out-of-range load data %h, expected 0", data));
		no_extra_done();
		store_op(bad_addr, `LSU_STORE_SW, ~ref_word(addr), 1'b1, 1'b1);
		no_extra_done();
		load_check(addr, `LSU_LOAD_LW);
		load_op(bad_addr + 1, `LSU_LOAD_LBU, 1'b1, 1'b0, data);
		check(data == '0, $sformatf("out-of-range byte load data %h, expected 0", data));
	endtask

	initial begin
		rstn        = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		void'($urandom(32'h8b368c46));
		repeat (4) @(posedge clock);
		#5;
		rstn = 1'b1;
		test_pass_through();
		test_word_rw();
		test_partial_stores();
		test_load_extend();
		test_out_of_range();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* lsu_mem_top.f */
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_store_align.sv
verilog/lsu_load_extend.sv
verilog/lsu_ctrl.sv
verilog/axi_lite_sram.sv
verilog/lsu_mem_top.sv
verif/lsu_mem_tb.sv
